/* all.f */
scramble_pkg.sv
word_deserializer.sv
channel_lane.sv
lane_combiner.sv
scrambler_top.sv
tb_scrambler.sv

/* channel_lane.sv */
// scrambler lane
// five registered stages, each gray, byte rotate or invert as the recipe says
`timescale 1ns/1ps

module channel_lane #(
	parameter logic [scramble_pkg::recipe_w-1:0] recipe = 15'b001_001_001_001_001
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [scramble_pkg::word_w-1:0] lane_in,
	input  logic                             in_valid,
	output logic [scramble_pkg::word_w-1:0] lane_word,
	output logic                             lane_valid
);
	import scramble_pkg::*;

	localparam int n_stages = recipe_w / 3;

	word_u                stage_q [0:n_stages-1];
	logic [n_stages-1:0]  valid_q;

	for (genvar g = 0; g < n_stages; g++) begin : g_stage
		localparam logic [2:0] code = recipe[3*g +: 3];

		word_u stage_d;

		if (g == 0) begin : g_first
			assign stage_d = lane_in;
		end else begin : g_next
			assign stage_d = stage_q[g-1];
		end

		always_ff @(posedge clk or posedge rst) begin
			if (rst)
				stage_q[g] <= '0;
			else
				stage_q[g] <= apply_stage(code, stage_d);
		end

		// catches a lane built with a code the stages do not know
		initial begin
			a_code_valid: assert (code == stage_gray || code == stage_rot || code == stage_inv)
				else $fatal(1, "lane recipe stage %0d has bad code %0d", g, code);
		end
	end

	// valid rides next to the data, one bit per stage
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			valid_q <= '0;
		else
			valid_q <= {valid_q[n_stages-2:0], in_valid};
	end

	assign lane_word  = stage_q[n_stages-1].word;
	assign lane_valid = valid_q[n_stages-1];

	a_lane_valid_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(lane_valid))
		else $error("lane_valid is unknown");

endmodule

/* lane_combiner.sv */
// lane combiner
// registered xor of the five lane results with the output valid
`timescale 1ns/1ps

module lane_combiner (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [scramble_pkg::word_w-1:0] w0,
	input  logic [scramble_pkg::word_w-1:0] w1,
	input  logic [scramble_pkg::word_w-1:0] w2,
	input  logic [scramble_pkg::word_w-1:0] w3,
	input  logic [scramble_pkg::word_w-1:0] w4,
	input  logic                             v0,
	input  logic                             v1,
	input  logic                             v2,
	input  logic                             v3,
	input  logic                             v4,
	output logic [scramble_pkg::word_w-1:0] out,
	output logic                             out_valid
);
	import scramble_pkg::*;

	logic [word_w-1:0] mix;

	assign mix = w0 ^ w1 ^ w2 ^ w3 ^ w4;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out       <= '0;
			out_valid <= 1'b0;
		end else begin
			out       <= mix;
			out_valid <= v0; // all lanes carry the same valid
		end
	end

	// lanes share one latency, so their valid bits move in lockstep
	a_valid_agree: assert property (@(posedge clk) disable iff (rst)
		(v0 == v1) && (v0 == v2) && (v0 == v3) && (v0 == v4))
		else $error("lane valid bits disagree");

endmodule

/* run.sh */
#!/bin/sh
# build and run the scrambler testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_scrambler -f all.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

if [ ! -x ./obj_dir/Vtb_scrambler ]; then
	echo "simulation binary was not built"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_scrambler 2>&1)
status=$?
printf '%s\n' "$sim_out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'TEST PASSED'; then
	exit 0
else
	echo "pass line not found in simulation output"
	exit 1
fi

/* scramble_pkg.sv */
// scrambler shared definitions
// word layout, stage codes and the three stage operations used by the lanes

package scramble_pkg;

	localparam int word_w = 32;

	// five 3-bit stage codes per lane, stage 0 in the low bits
	localparam int recipe_w = 15;

	localparam logic [2:0] stage_gray = 3'd1;
	localparam logic [2:0] stage_rot  = 3'd2;
	localparam logic [2:0] stage_inv  = 3'd3;

	// same 32 bits seen as a whole word or as four bytes
	typedef union packed {
		logic [word_w-1:0] word;
		logic [3:0][7:0]   bytes; // bytes[0] is the least significant
	} word_u;

	// binary to gray
	function automatic word_u gray_word(word_u w);
		word_u r;
		r.word = w.word ^ (w.word >> 1);
		return r;
	endfunction

	// byte rotate toward byte 0, amount from the word's own low bits
	function automatic word_u rot_word(word_u w);
		word_u r;
		logic [1:0] amt;
		amt = w.bytes[0][1:0];
		for (int i = 0; i < 4; i++) begin
			r.bytes[i] = w.bytes[(i + amt) % 4];
		end
		return r;
	endfunction

	function automatic word_u inv_word(word_u w);
		word_u r;
		r.word = ~w.word;
		return r;
	endfunction

	// dispatch on a stage code, unknown codes pass the word unchanged
	function automatic word_u apply_stage(logic [2:0] code, word_u w);
		word_u r;
		case (code)
			stage_gray: r = gray_word(w);
			stage_rot:  r = rot_word(w);
			stage_inv:  r = inv_word(w);
			default:    r = w;
		endcase
		return r;
	endfunction

endpackage

/* scrambler_top.sv */
// five-lane word scrambler
// history of five words, one recipe lane per word, xor-combined output
`timescale 1ns/1ps

module scrambler_top (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [scramble_pkg::word_w-1:0] in,
	input  logic                             in_valid,
	output logic [scramble_pkg::word_w-1:0] out,
	output logic                             out_valid
);
	import scramble_pkg::*;

	// stage 0 at the right
	localparam logic [recipe_w-1:0] recipe0 = {stage_rot, stage_gray, stage_inv, stage_rot, stage_gray};
	localparam logic [recipe_w-1:0] recipe1 = {stage_gray, stage_rot, stage_rot, stage_gray, stage_inv};
	localparam logic [recipe_w-1:0] recipe2 = {stage_gray, stage_rot, stage_rot, stage_rot, stage_gray};
	localparam logic [recipe_w-1:0] recipe3 = {stage_inv, stage_rot, stage_inv, stage_gray, stage_rot};
	localparam logic [recipe_w-1:0] recipe4 = {stage_inv, stage_rot, stage_gray, stage_gray, stage_rot};

	logic [word_w-1:0] slot0, slot1, slot2, slot3, slot4;
	logic              slot_valid;
	logic [word_w-1:0] lane_word0, lane_word1, lane_word2, lane_word3, lane_word4;
	logic              lane_valid0, lane_valid1, lane_valid2, lane_valid3, lane_valid4;

	word_deserializer u_deser (
		.clk(clk), .rst(rst), .in(in), .in_valid(in_valid),
		.slot0(slot0), .slot1(slot1), .slot2(slot2), .slot3(slot3), .slot4(slot4),
		.slot_valid(slot_valid)
	);

	// slot c counted back from the newest feeds lane c
	channel_lane #(.recipe(recipe0)) u_lane0 (
		.clk(clk), .rst(rst), .lane_in(slot0), .in_valid(slot_valid),
		.lane_word(lane_word0), .lane_valid(lane_valid0)
	);
	channel_lane #(.recipe(recipe1)) u_lane1 (
		.clk(clk), .rst(rst), .lane_in(slot1), .in_valid(slot_valid),
		.lane_word(lane_word1), .lane_valid(lane_valid1)
	);
	channel_lane #(.recipe(recipe2)) u_lane2 (
		.clk(clk), .rst(rst), .lane_in(slot2), .in_valid(slot_valid),
		.lane_word(lane_word2), .lane_valid(lane_valid2)
	);
	channel_lane #(.recipe(recipe3)) u_lane3 (
		.clk(clk), .rst(rst), .lane_in(slot3), .in_valid(slot_valid),
		.lane_word(lane_word3), .lane_valid(lane_valid3)
	);
	channel_lane #(.recipe(recipe4)) u_lane4 (
		.clk(clk), .rst(rst), .lane_in(slot4), .in_valid(slot_valid),
		.lane_word(lane_word4), .lane_valid(lane_valid4)
	);

	lane_combiner u_comb (
		.clk(clk), .rst(rst),
		.w0(lane_word0), .w1(lane_word1), .w2(lane_word2), .w3(lane_word3), .w4(lane_word4),
		.v0(lane_valid0), .v1(lane_valid1), .v2(lane_valid2), .v3(lane_valid3),
		.v4(lane_valid4),
		.out(out), .out_valid(out_valid)
	);

endmodule

/* tb_scrambler.sv */
// scrambler testbench
// table-driven stimulus checked against a behavioral model of the five lanes
`timescale 1ns/1ps

module tb_scrambler;

	localparam logic [2:0]  op_g      = 3'd1;
	localparam logic [2:0]  op_r      = 3'd2;
	localparam logic [2:0]  op_i      = 3'd3;
	localparam logic [31:0] lfsr_seed = 32'h6877;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	typedef struct packed {
		logic        rst;
		logic        valid;
		logic        src_lfsr; // word drawn from the lfsr at apply time
		logic [31:0] word;
	} stim_t;

	logic        clk;
	logic        rst;
	logic [31:0] in;
	logic        in_valid;
	logic [31:0] out;
	logic        out_valid;

	stim_t       tbl [$];
	logic        table_ready = 1'b0;
	int          cyc = 0;
	logic [31:0] lfsr_state;
	logic [31:0] hist [0:4]; // [0] newest accepted word
	int          exp_tag [$];
	logic [31:0] exp_word [$];

	// stage 0 first
	logic [2:0] lane_ops [0:4][0:4] = '{
		'{op_g, op_r, op_i, op_g, op_r},
		'{op_i, op_g, op_r, op_r, op_g},
		'{op_g, op_r, op_r, op_r, op_g},
		'{op_r, op_g, op_i, op_r, op_i},
		'{op_r, op_g, op_g, op_r, op_i}
	};

	scrambler_top dut (
		.clk(clk), .rst(rst), .in(in), .in_valid(in_valid),
		.out(out), .out_valid(out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, actual,
				expected);
			$display("TEST FAILED");
			$fatal(1, "stopping on first mismatch");
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = {1'b0, s[31:1]};
		if (s[0])
			n = n ^ lfsr_taps;
		return n;
	endfunction

	task automatic draw_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w[b] = lfsr_state[0]; // one step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic logic [31:0] model_stage(input logic [2:0] op, input logic [31:0] w);
		logic [63:0] dbl;
		logic [31:0] r;
		int          amt;
		amt = {30'd0, w[1:0]};
		dbl = {w, w} >> (8 * amt); // byte i takes byte i+amt
		case (op)
			op_g:    r = w ^ (w >> 1);
			op_r:    r = dbl[31:0];
			op_i:    r = ~w;
			default: r = w;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] model_out();
		logic [31:0] acc;
		logic [31:0] w;
		acc = '0;
		for (int c = 0; c < 5; c++) begin
			w = hist[c];
			for (int s = 0; s < 5; s++)
				w = model_stage(lane_ops[c][s], w);
			acc = acc ^ w;
		end
		return acc;
	endfunction

	task automatic add_entry(input logic r, input logic v, input logic l, input logic [31:0] w);
		stim_t e;
		e.rst      = r;
		e.valid    = v;
		e.src_lfsr = l;
		e.word     = w;
		tbl.push_back(e);
	endtask

	task automatic build_table();
		logic [31:0] iso [0:4] = '{32'hC0FF_EE00, 32'h1234_5601, 32'hA5A5_5A02,
			32'h0F1E_2D03, 32'h8000_0001};
		logic [12:0] gap_valid = 13'b1_0110_1000_1001;
		repeat (3) add_entry(1'b0, 1'b0, 1'b0, 32'h0);
		// lone word walks slot 0 to slot 4
		for (int k = 0; k < 5; k++) begin
			add_entry(1'b0, 1'b1, 1'b0, iso[k]);
			repeat (4) add_entry(1'b0, 1'b1, 1'b0, 32'h0);
		end
		for (int k = 0; k < 13; k++)
			add_entry(1'b0, gap_valid[k], 1'b0, 32'h9E37_79B9 * 32'(k + 1));
		repeat (48) add_entry(1'b0, 1'b1, 1'b1, 32'h0);
		for (int k = 0; k < 16; k++)
			add_entry(1'b0, (k % 3) != 0, 1'b1, 32'h0);
		repeat (10) add_entry(1'b0, 1'b1, 1'b1, 32'h0);
		repeat (3) add_entry(1'b1, 1'b1, 1'b1, 32'h0); // mid-stream reset
		repeat (12) add_entry(1'b0, 1'b1, 1'b1, 32'h0);
	endtask

	task automatic apply_entry(input stim_t e);
		logic [31:0] w;
		if (e.src_lfsr)
			draw_word(w);
		else
			w = e.word;
		rst      = e.rst;
		in       = w;
		in_valid = e.valid;
		if (e.rst) begin
			exp_tag.delete();
			exp_word.delete();
			for (int c = 0; c < 5; c++)
				hist[c] = '0;
		end else if (e.valid) begin
			for (int c = 4; c > 0; c--)
				hist[c] = hist[c-1];
			hist[0] = w;
			exp_tag.push_back(cyc + 8); // accepted next edge, out 7 edges later
			exp_word.push_back(model_out());
		end
	endtask

	initial begin : monitor
		forever begin
			@(posedge clk);
			cyc = cyc + 1;
			#1;
			if (rst) begin
				check_value(out, 32'h0, "out in reset");
				check_value(32'(out_valid), 32'h0, "out_valid in reset");
			end else if (exp_tag.size() != 0 && exp_tag[0] == cyc) begin
				check_value(32'(out_valid), 32'h1, "out_valid for accepted word");
				check_value(out, exp_word[0], $sformatf("out at cycle %0d", cyc));
				void'(exp_tag.pop_front());
				void'(exp_word.pop_front());
			end else begin
				check_value(32'(out_valid), 32'h0, "out_valid with no word due");
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = 8 + tbl.size() + 20;
		#(limit * 40);
		$display("timeout: run did not finish within %0d clock cycles", limit);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		rst        = 1'b1;
		in         = '0;
		in_valid   = 1'b0;
		lfsr_state = lfsr_seed;
		for (int c = 0; c < 5; c++)
			hist[c] = '0;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		#1;
		check_value(out, 32'h0, "out right after reset");
		check_value(32'(out_valid), 32'h0, "out_valid right after reset");
		foreach (tbl[i]) begin
			@(posedge clk);
			#2;
			apply_entry(tbl[i]);
		end
		@(posedge clk);
		#2;
		rst      = 1'b0;
		in       = '0;
		in_valid = 1'b0;
		while (exp_tag.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk); // valid must stay low once drained
		#5;
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* word_deserializer.sv */
// word deserializer
// keeps the five most recent accepted words and snapshots them for the lanes
`timescale 1ns/1ps

module word_deserializer (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [scramble_pkg::word_w-1:0] in,
	input  logic                             in_valid,
	output logic [scramble_pkg::word_w-1:0] slot0,
	output logic [scramble_pkg::word_w-1:0] slot1,
	output logic [scramble_pkg::word_w-1:0] slot2,
	output logic [scramble_pkg::word_w-1:0] slot3,
	output logic [scramble_pkg::word_w-1:0] slot4,
	output logic                             slot_valid
);
	import scramble_pkg::*;

	logic [word_w-1:0] shift_q [0:4]; // [0] newest
	logic              acc_valid;

	// history only moves on an accepted word
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 5; i++)
				shift_q[i] <= '0;
			acc_valid <= 1'b0;
		end else begin
			if (in_valid) begin
				shift_q[0] <= in;
				for (int i = 1; i < 5; i++)
					shift_q[i] <= shift_q[i-1];
			end
			acc_valid <= in_valid;
		end
	end

	// capture register, one edge behind the shift
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			slot0      <= '0;
			slot1      <= '0;
			slot2      <= '0;
			slot3      <= '0;
			slot4      <= '0;
			slot_valid <= 1'b0;
		end else begin
			slot0      <= shift_q[0];
			slot1      <= shift_q[1];
			slot2      <= shift_q[2];
			slot3      <= shift_q[3];
			slot4      <= shift_q[4];
			slot_valid <= acc_valid; // lines up with the snapshot
		end
	end

	a_in_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(in_valid))
		else $error("in_valid is unknown");

endmodule
